// ==== b200_core.sv ====
////////////////////////////////////////
// b200 core control plane top level
////////////////////////////////////////
`timescale 1ns/1ps

module b200_core (
    input  logic                      radio_clk,
    input  logic                      bus_rst,
    input  logic                      i_ctrl_valid,
    input  b200_core_pkg::word_t      i_ctrl_data,
    output logic                      o_ctrl_credit,
    output logic                      o_resp_valid,
    output b200_core_pkg::word_t      o_resp_data,
    output b200_core_pkg::sid_t       o_resp_sid,
    input  logic                      i_resp_credit,
    input  logic                      i_pps_int,
    input  logic                      i_pps_ext,
    input  b200_core_pkg::lock_t      i_lock_signals,
    input  b200_core_pkg::set_data_t  i_rb_misc,
    output b200_core_pkg::set_data_t  o_misc_outs,
    output logic                      o_pps,
    output logic                      o_time_sync
);
    import b200_core_pkg::*;

    logic     local_valid, local_ready;
    word_t    local_data;
    logic     loop_valid, loop_ready;
    word_t    loop_data;
    logic     lresp_valid, lresp_ready;
    word_t    lresp_data;
    sid_t     lresp_sid;
    pps_sel_t pps_sel;

    ctrl_demux u_ctrl_demux (
        .radio_clk(radio_clk), .bus_rst(bus_rst),
        .i_ctrl_valid(i_ctrl_valid), .i_ctrl_data(i_ctrl_data), .o_ctrl_credit(o_ctrl_credit),
        .o_local_valid(local_valid), .i_local_ready(local_ready), .o_local_data(local_data),
        .o_loop_valid(loop_valid), .i_loop_ready(loop_ready), .o_loop_data(loop_data)
    );

    core_ctrl_proc u_core_ctrl_proc (
        .radio_clk(radio_clk), .bus_rst(bus_rst),
        .i_local_valid(local_valid), .o_local_ready(local_ready), .i_local_data(local_data),
        .o_lresp_valid(lresp_valid), .i_lresp_ready(lresp_ready),
        .o_lresp_data(lresp_data), .o_lresp_sid(lresp_sid),
        .i_lock_signals(i_lock_signals), .i_rb_misc(i_rb_misc),
        .o_misc_outs(o_misc_outs), .o_pps_sel(pps_sel), .o_time_sync(o_time_sync)
    );

    pps_select u_pps_select (
        .radio_clk(radio_clk), .bus_rst(bus_rst),
        .i_pps_int(i_pps_int), .i_pps_ext(i_pps_ext),
        .i_pps_sel(pps_sel), .o_pps(o_pps)
    );

    resp_mux u_resp_mux (
        .radio_clk(radio_clk), .bus_rst(bus_rst),
        .i_lresp_valid(lresp_valid), .o_lresp_ready(lresp_ready),
        .i_lresp_data(lresp_data), .i_lresp_sid(lresp_sid),
        .i_loop_valid(loop_valid), .o_loop_ready(loop_ready), .i_loop_data(loop_data),
        .i_resp_credit(i_resp_credit),
        .o_resp_valid(o_resp_valid), .o_resp_data(o_resp_data), .o_resp_sid(o_resp_sid)
    );

endmodule

// ==== b200_core_pkg.sv ====
////////////////////////////////////////
// b200 core control plane definitions
// widths, stream IDs, setting addresses, credit counts
////////////////////////////////////////
package b200_core_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    typedef logic [63:0] word_t;
    typedef logic [7:0]  sid_t;
    typedef logic [7:0]  set_addr_t;
    typedef logic [31:0] set_data_t;
    typedef logic [1:0]  rb_sel_t;
    typedef logic [1:0]  pps_sel_t;
    typedef logic [1:0]  lock_t;

    ////////////////////////////////////////
    // stream routing
    ////////////////////////////////////////
    localparam sid_t SID_MASK  = 8'hF0;
    localparam sid_t SID_LOCAL = 8'h40;
    // stands in for the absent second radio
    localparam sid_t SID_LOOP  = 8'h20;

    // setting register addresses
    localparam set_addr_t SR_CORE_MISC     = 8'd16;
    localparam set_addr_t SR_CORE_READBACK = 8'd32;
    localparam set_addr_t SR_CORE_GPSDO_ST = 8'd40;
    localparam set_addr_t SR_CORE_SYNC     = 8'd48;

    // readback constants
    localparam logic [15:0] COMPAT_MAJOR     = 16'h000D;
    localparam logic [15:0] COMPAT_MINOR     = 16'h0000;
    localparam logic [31:0] COMPAT_SIGNATURE = 32'hACE0BA5E;
    localparam logic [7:0]  RADIO_STATUS     = 8'd1;

    // pps source encodings
    localparam pps_sel_t PPS_SEL_GPSDO = 2'd0;
    localparam pps_sel_t PPS_SEL_EXT   = 2'd1;
    localparam pps_sel_t PPS_SEL_INT   = 2'd2;
    localparam pps_sel_t PPS_SEL_OFF   = 2'd3;

    ////////////////////////////////////////
    // flow control and timing
    ////////////////////////////////////////
    localparam int CTRL_CREDITS   = 4;
    localparam int RESP_CREDITS   = 2;
    localparam int INT_PPS_PERIOD = 64;

    typedef logic [$clog2(CTRL_CREDITS)-1:0]   fifo_ptr_t;
    typedef logic [$clog2(CTRL_CREDITS+1)-1:0] fifo_cnt_t;
    typedef logic [$clog2(RESP_CREDITS+1)-1:0] resp_cnt_t;
    typedef logic [$clog2(INT_PPS_PERIOD)-1:0] pps_cnt_t;

    // round-robin owner of the response port
    typedef enum logic {
        PRIO_LOCAL = 1'b0,
        PRIO_LOOP  = 1'b1
    } rr_prio_t;

endpackage

// ==== core_ctrl_proc.sv ====
////////////////////////////////////////
// core control endpoint with setting registers,
// lock synchroniser and readback responses
////////////////////////////////////////
`timescale 1ns/1ps

module core_ctrl_proc (
    input  logic                      radio_clk,
    input  logic                      bus_rst,
    input  logic                      i_local_valid,
    output logic                      o_local_ready,
    input  b200_core_pkg::word_t      i_local_data,
    output logic                      o_lresp_valid,
    input  logic                      i_lresp_ready,
    output b200_core_pkg::word_t      o_lresp_data,
    output b200_core_pkg::sid_t       o_lresp_sid,
    input  b200_core_pkg::lock_t      i_lock_signals,
    input  b200_core_pkg::set_data_t  i_rb_misc,
    output b200_core_pkg::set_data_t  o_misc_outs,
    output b200_core_pkg::pps_sel_t   o_pps_sel,
    output logic                      o_time_sync
);
    import b200_core_pkg::*;

    logic      accept;
    set_addr_t set_addr;
    set_data_t set_data;

    // setting registers and their next values
    set_data_t   misc_q;
    set_data_t   misc_nxt;
    rb_sel_t     rb_sel_q;
    rb_sel_t     rb_sel_nxt;
    logic [7:0]  gpsdo_q;
    logic [7:0]  gpsdo_nxt;
    pps_sel_t    pps_sel_q;
    pps_sel_t    pps_sel_nxt;
    logic        time_sync_q;
    logic        time_sync_nxt;

    lock_t       lock_meta;
    lock_t       lock_sync;
    word_t       rb_word;

    // a held response blocks new commands
    assign o_local_ready = !o_lresp_valid || i_lresp_ready;
    assign accept        = i_local_valid && o_local_ready;

    assign set_addr = i_local_data[15:8];
    assign set_data = i_local_data[47:16];

    ////////////////////////////////////////
    // setting decode
    ////////////////////////////////////////
    always_comb begin
        misc_nxt      = misc_q;
        rb_sel_nxt    = rb_sel_q;
        gpsdo_nxt     = gpsdo_q;
        pps_sel_nxt   = pps_sel_q;
        time_sync_nxt = time_sync_q;
        if (accept) begin
            case (set_addr)
                SR_CORE_MISC:     misc_nxt   = set_data;
                SR_CORE_READBACK: rb_sel_nxt = set_data[1:0];
                SR_CORE_GPSDO_ST: gpsdo_nxt  = set_data[7:0];
                SR_CORE_SYNC: begin
                    pps_sel_nxt   = set_data[1:0];
                    time_sync_nxt = set_data[2];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            misc_q      <= '0;
            rb_sel_q    <= '0;
            pps_sel_q   <= '0;
            time_sync_q <= 1'b0;
            o_time_sync <= 1'b0;
        end else begin
            misc_q      <= misc_nxt;
            rb_sel_q    <= rb_sel_nxt;
            pps_sel_q   <= pps_sel_nxt;
            time_sync_q <= time_sync_nxt;
            // one register stage for time sync
            o_time_sync <= time_sync_q;
        end
    end

    // gpsdo status survives reset
    always_ff @(posedge radio_clk) begin
        gpsdo_q <= gpsdo_nxt;
    end

    assign o_misc_outs = misc_q;
    assign o_pps_sel   = pps_sel_q;

    // two-flop front-end lock synchroniser
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            lock_meta <= '0;
            lock_sync <= '0;
        end else begin
            lock_meta <= i_lock_signals;
            lock_sync <= lock_meta;
        end
    end

    ////////////////////////////////////////
    // readback and response
    ////////////////////////////////////////
    // built from next values so a response sees its own write
    always_comb begin
        case (rb_sel_nxt)
            2'd0: rb_word = {COMPAT_SIGNATURE, COMPAT_MAJOR, COMPAT_MINOR};
            2'd1: rb_word = {32'b0, misc_nxt};
            2'd2: rb_word = {16'b0, RADIO_STATUS, gpsdo_nxt, i_rb_misc};
            2'd3: rb_word = {62'b0, lock_sync};
        endcase
    end

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            o_lresp_valid <= 1'b0;
        end else if (accept) begin
            o_lresp_valid <= 1'b1;
        end else if (i_lresp_ready) begin
            o_lresp_valid <= 1'b0;
        end
    end

    always_ff @(posedge radio_clk) begin
        if (accept) begin
            o_lresp_data <= rb_word;
            o_lresp_sid  <= i_local_data[7:0];
        end
    end

endmodule

// ==== ctrl_demux.sv ====
////////////////////////////////////////
// command FIFO with host credits and
// SID routing to local and loopback endpoints
////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_demux (
    input  logic                  radio_clk,
    input  logic                  bus_rst,
    input  logic                  i_ctrl_valid,
    input  b200_core_pkg::word_t  i_ctrl_data,
    output logic                  o_ctrl_credit,
    output logic                  o_local_valid,
    input  logic                  i_local_ready,
    output b200_core_pkg::word_t  o_local_data,
    output logic                  o_loop_valid,
    input  logic                  i_loop_ready,
    output b200_core_pkg::word_t  o_loop_data
);
    import b200_core_pkg::*;

    word_t     mem [CTRL_CREDITS];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    word_t     head;
    logic      full;
    logic      empty;
    logic      head_to_loop;
    logic      push;
    logic      pop;

    assign full  = (count == fifo_cnt_t'(CTRL_CREDITS));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    // unknown classes fall through to the local endpoint
    assign head_to_loop = ((head[7:0] & SID_MASK) == SID_LOOP);

    // head only waits on its own output register
    assign pop  = !empty && (head_to_loop ? (!o_loop_valid || i_loop_ready)
                                          : (!o_local_valid || i_local_ready));
    assign push = i_ctrl_valid && (!full || pop);

    // one credit back to the host per word leaving
    assign o_ctrl_credit = pop;

    always_ff @(posedge radio_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_ctrl_data;
        end
    end

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // output registers
    ////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            o_local_valid <= 1'b0;
            o_loop_valid  <= 1'b0;
        end else begin
            if (pop && !head_to_loop) begin
                o_local_valid <= 1'b1;
            end else if (i_local_ready) begin
                o_local_valid <= 1'b0;
            end
            if (pop && head_to_loop) begin
                o_loop_valid <= 1'b1;
            end else if (i_loop_ready) begin
                o_loop_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge radio_clk) begin
        if (pop && !head_to_loop) begin
            o_local_data <= head;
        end
        if (pop && head_to_loop) begin
            o_loop_data <= head;
        end
    end

endmodule

// ==== pps_select.sv ====
////////////////////////////////////////
// internal PPS generator and PPS source mux
////////////////////////////////////////
`timescale 1ns/1ps

module pps_select (
    input  logic                     radio_clk,
    input  logic                     bus_rst,
    input  logic                     i_pps_int,
    input  logic                     i_pps_ext,
    input  b200_core_pkg::pps_sel_t  i_pps_sel,
    output logic                     o_pps
);
    import b200_core_pkg::*;

    pps_cnt_t   pps_cnt;
    logic       pps_gen;
    // bit 0 gpsdo, bit 1 external, bit 2 internal
    logic [2:0] pps_meta;
    logic [2:0] pps_sync;

    // internal pps is high for the first half period
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            pps_cnt <= '0;
            pps_gen <= 1'b0;
        end else begin
            if (pps_cnt == pps_cnt_t'(INT_PPS_PERIOD - 1)) begin
                pps_cnt <= '0;
            end else begin
                pps_cnt <= pps_cnt + 1'b1;
            end
            pps_gen <= (pps_cnt < pps_cnt_t'(INT_PPS_PERIOD / 2));
        end
    end

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            pps_meta <= '0;
            pps_sync <= '0;
            o_pps    <= 1'b0;
        end else begin
            pps_meta <= {pps_gen, i_pps_ext, i_pps_int};
            pps_sync <= pps_meta;
            case (i_pps_sel)
                PPS_SEL_GPSDO: o_pps <= pps_sync[0];
                PPS_SEL_EXT:   o_pps <= pps_sync[1];
                PPS_SEL_INT:   o_pps <= pps_sync[2];
                PPS_SEL_OFF:   o_pps <= 1'b0;
            endcase
        end
    end

endmodule

// ==== resp_mux.sv ====
////////////////////////////////////////
// round-robin response merge with
// credit-limited output port
////////////////////////////////////////
`timescale 1ns/1ps

module resp_mux (
    input  logic                  radio_clk,
    input  logic                  bus_rst,
    input  logic                  i_lresp_valid,
    output logic                  o_lresp_ready,
    input  b200_core_pkg::word_t  i_lresp_data,
    input  b200_core_pkg::sid_t   i_lresp_sid,
    input  logic                  i_loop_valid,
    output logic                  o_loop_ready,
    input  b200_core_pkg::word_t  i_loop_data,
    input  logic                  i_resp_credit,
    output logic                  o_resp_valid,
    output b200_core_pkg::word_t  o_resp_data,
    output b200_core_pkg::sid_t   o_resp_sid
);
    import b200_core_pkg::*;

    resp_cnt_t credits;
    rr_prio_t  prio;
    logic      has_credit;
    logic      grant_local;
    logic      grant_loop;
    logic      grant;

    assign has_credit = (credits != '0);

    // priority side wins a tie
    assign grant_local = has_credit && i_lresp_valid &&
                         (!i_loop_valid || prio == PRIO_LOCAL);
    assign grant_loop  = has_credit && i_loop_valid &&
                         (!i_lresp_valid || prio == PRIO_LOOP);
    assign grant       = grant_local || grant_loop;

    assign o_lresp_ready = grant_local;
    assign o_loop_ready  = grant_loop;

    ////////////////////////////////////////
    // credit count and priority
    ////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            credits <= resp_cnt_t'(RESP_CREDITS);
            prio    <= PRIO_LOCAL;
        end else begin
            case ({grant, i_resp_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
            if (grant_local) begin
                prio <= PRIO_LOOP;
            end else if (grant_loop) begin
                prio <= PRIO_LOCAL;
            end
        end
    end

    // output stage
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= grant;
        end
    end

    always_ff @(posedge radio_clk) begin
        if (grant_local) begin
            o_resp_data <= i_lresp_data;
            o_resp_sid  <= i_lresp_sid;
        end else if (grant_loop) begin
            // echo keeps the sid field of the word itself
            o_resp_data <= i_loop_data;
            o_resp_sid  <= i_loop_data[7:0];
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the b200 core testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_b200_core -f vlog.f -o sim_b200
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_b200 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0

// ==== tb_b200_core.sv ====
////////////////////////////////////////
// testbench for the b200 core control plane
// reference readback model, credit host, checker
////////////////////////////////////////
`timescale 1ns/1ps

module tb_b200_core;
    import b200_core_pkg::*;

    localparam int N_RAND         = 60;
    localparam int NUM_CMDS       = 8 + 10 + N_RAND + 4;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * 40 + 2000;

    logic      radio_clk;
    logic      bus_rst;
    logic      i_ctrl_valid;
    word_t     i_ctrl_data;
    logic      o_ctrl_credit;
    logic      o_resp_valid;
    word_t     o_resp_data;
    sid_t      o_resp_sid;
    logic      i_resp_credit;
    logic      i_pps_int;
    logic      i_pps_ext;
    lock_t     i_lock_signals;
    set_data_t i_rb_misc;
    set_data_t o_misc_outs;
    logic      o_pps;
    logic      o_time_sync;

    // model state of the setting registers
    set_data_t   m_misc;
    rb_sel_t     m_rb_sel;
    logic [7:0]  m_gpsdo;
    logic [2:0]  m_sync;

    // expected {sid, word} per endpoint
    logic [71:0] exp_local[$];
    logic [71:0] exp_loop[$];
    logic [71:0] resp_exp;
    logic        is_loop;
    logic        pending;

    int          seed;
    int          host_credits;
    int          resp_avail;
    int          owed;
    int          gap_left;
    int          credit_gap;
    int          mismatch_errs;
    int          other_errs;
    int          sent;
    int          resp_seen;
    int          credit_seen;
    int          i;
    logic [15:0] tag;
    logic [31:0] r;
    sid_t        sid;
    set_addr_t   addr;
    logic        seen_hi;
    logic        seen_lo;

    b200_core uut (
        .radio_clk(radio_clk), .bus_rst(bus_rst),
        .i_ctrl_valid(i_ctrl_valid), .i_ctrl_data(i_ctrl_data), .o_ctrl_credit(o_ctrl_credit),
        .o_resp_valid(o_resp_valid), .o_resp_data(o_resp_data), .o_resp_sid(o_resp_sid),
        .i_resp_credit(i_resp_credit),
        .i_pps_int(i_pps_int), .i_pps_ext(i_pps_ext),
        .i_lock_signals(i_lock_signals), .i_rb_misc(i_rb_misc),
        .o_misc_outs(o_misc_outs), .o_pps(o_pps), .o_time_sync(o_time_sync)
    );

    always #2 radio_clk = ~radio_clk;

    ////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////
    // apply one command to the model and return its readback word
    function automatic word_t ref_readback(input word_t cmd);
        set_addr_t a;
        set_data_t d;
        word_t     rb;
        a = cmd[15:8];
        d = cmd[47:16];
        case (a)
            SR_CORE_MISC:     m_misc   = d;
            SR_CORE_READBACK: m_rb_sel = d[1:0];
            SR_CORE_GPSDO_ST: m_gpsdo  = d[7:0];
            SR_CORE_SYNC:     m_sync   = d[2:0];
            default: ;
        endcase
        case (m_rb_sel)
            2'd0: rb = {COMPAT_SIGNATURE, COMPAT_MAJOR, COMPAT_MINOR};
            2'd1: rb = {32'b0, m_misc};
            2'd2: rb = {16'b0, RADIO_STATUS, m_gpsdo, i_rb_misc};
            default: rb = {62'b0, i_lock_signals};
        endcase
        return rb;
    endfunction

    function automatic word_t make_cmd(input sid_t s, input set_addr_t a, input set_data_t d);
        tag = tag + 16'd1;
        return {tag, d, a, s};
    endfunction

    // one word per call while a credit is held
    task automatic send_cmd(input word_t cmd);
        while (host_credits == 0) begin
            @(posedge radio_clk);
            #1;
        end
        if ((cmd[7:0] & SID_MASK) == SID_LOOP) begin
            exp_loop.push_back({cmd[7:0], cmd});
        end else begin
            exp_local.push_back({cmd[7:0], ref_readback(cmd)});
        end
        i_ctrl_valid = 1'b1;
        i_ctrl_data  = cmd;
        host_credits = host_credits - 1;
        sent         = sent + 1;
        @(posedge radio_clk);
        #1;
        i_ctrl_valid = 1'b0;
    endtask

    task automatic drain_responses();
        while (exp_local.size() != 0 || exp_loop.size() != 0) begin
            @(negedge radio_clk);
        end
        @(posedge radio_clk);
        #1;
    endtask

    task automatic check_pps_follows(input pps_sel_t sel);
        logic seen;
        seen = 1'b0;
        send_cmd(make_cmd(SID_LOCAL, SR_CORE_SYNC, {30'b0, sel}));
        drain_responses();
        if (sel == PPS_SEL_GPSDO) begin
            i_pps_int = 1'b1;
        end else begin
            i_pps_ext = 1'b1;
        end
        repeat (10) begin
            @(negedge radio_clk);
            if (o_pps) begin
                seen = 1'b1;
            end
        end
        @(posedge radio_clk);
        #1;
        i_pps_int = 1'b0;
        i_pps_ext = 1'b0;
        assert (seen) else begin
            other_errs++;
            $display("%0t: o_pps never went high while PPS source %0d was high", $time, sel);
        end
    endtask

    ////////////////////////////////////////
    // response credit return after random gaps
    ////////////////////////////////////////
    always begin
        @(posedge radio_clk);
        #1;
        i_resp_credit = 1'b0;
        if (gap_left > 0) begin
            gap_left = gap_left - 1;
        end else if (!bus_rst && owed > 0) begin
            i_resp_credit = 1'b1;
            owed          = owed - 1;
            gap_left      = ($random(seed) & 32'h7fff_ffff) % (credit_gap + 1);
        end
    end

    ////////////////////////////////////////
    // checker
    ////////////////////////////////////////
    always @(negedge radio_clk) begin
        if (!bus_rst) begin
            if (o_resp_valid) begin
                resp_seen = resp_seen + 1;
                owed      = owed + 1;
                assert (resp_avail > 0) else begin
                    other_errs++;
                    $display("%0t: response sent without a response credit", $time);
                end
                if (resp_avail > 0) begin
                    resp_avail = resp_avail - 1;
                end
                is_loop = ((o_resp_sid & SID_MASK) == SID_LOOP);
                pending = is_loop ? (exp_loop.size() != 0) : (exp_local.size() != 0);
                assert (pending) else begin
                    other_errs++;
                    $display("%0t: response for sid %h with no command pending",
                             $time, o_resp_sid);
                end
                if (pending) begin
                    if (is_loop) begin
                        resp_exp = exp_loop.pop_front();
                    end else begin
                        resp_exp = exp_local.pop_front();
                    end
                    assert (o_resp_data === resp_exp[63:0]) else begin
                        mismatch_errs++;
                        $display("Mismatch at %0t: o_resp_data expected %h got %h",
                                 $time, resp_exp[63:0], o_resp_data);
                    end
                    assert (o_resp_sid === resp_exp[71:64]) else begin
                        mismatch_errs++;
                        $display("Mismatch at %0t: o_resp_sid expected %h got %h",
                                 $time, resp_exp[71:64], o_resp_sid);
                    end
                end
            end
            if (i_resp_credit) begin
                resp_avail = resp_avail + 1;
            end
            if (o_ctrl_credit) begin
                credit_seen = credit_seen + 1;
                assert (host_credits < CTRL_CREDITS) else begin
                    other_errs++;
                    $display("%0t: command credit returned with no command outstanding", $time);
                end
                if (host_credits < CTRL_CREDITS) begin
                    host_credits = host_credits + 1;
                end
            end
        end
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge radio_clk);
        $display("watchdog expired after %0d cycles, %0d local and %0d loopback responses missing",
                 TIMEOUT_CYCLES, exp_local.size(), exp_loop.size());
        $display("errors: %0d mismatch, %0d other", mismatch_errs, other_errs + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    initial begin
        radio_clk      = 1'b0;
        bus_rst        = 1'b1;
        i_ctrl_valid   = 1'b0;
        i_ctrl_data    = '0;
        i_resp_credit  = 1'b0;
        i_pps_int      = 1'b0;
        i_pps_ext      = 1'b0;
        i_lock_signals = 2'b10;
        i_rb_misc      = 32'hC0FF_EE42;
        m_misc         = '0;
        m_rb_sel       = '0;
        m_gpsdo        = 'x;
        m_sync         = '0;
        seed           = 29383;
        host_credits   = CTRL_CREDITS;
        resp_avail     = RESP_CREDITS;
        owed           = 0;
        gap_left       = 0;
        credit_gap     = 2;
        mismatch_errs  = 0;
        other_errs     = 0;
        sent           = 0;
        resp_seen      = 0;
        credit_seen    = 0;
        tag            = '0;
        repeat (4) @(posedge radio_clk);
        #1;
        bus_rst = 1'b0;

        // idle after reset
        repeat (20) @(negedge radio_clk);
        assert (resp_seen == 0 && credit_seen == 0) else begin
            other_errs++;
            $display("%0t: DUT was not idle after reset", $time);
        end
        @(posedge radio_clk);
        #1;

        // settings and all four readback slots
        send_cmd(make_cmd(SID_LOCAL, SR_CORE_READBACK, 32'd0));
        send_cmd(make_cmd(SID_LOCAL, SR_CORE_MISC, 32'hA5A5_0F0F));
        send_cmd(make_cmd(SID_LOCAL, SR_CORE_READBACK, 32'd1));
        send_cmd(make_cmd(SID_LOCAL, SR_CORE_GPSDO_ST, 32'h0000_003C));
        send_cmd(make_cmd(SID_LOCAL, SR_CORE_READBACK, 32'd2));
        send_cmd(make_cmd(SID_LOCAL, SR_CORE_READBACK, 32'd3));
        send_cmd(make_cmd(SID_LOCAL, SR_CORE_MISC, 32'h0000_00FF));
        send_cmd(make_cmd(SID_LOCAL, 8'd99, 32'hDEAD_BEEF));
        drain_responses();
        assert (o_misc_outs === m_misc) else begin
            mismatch_errs++;
            $display("Mismatch at %0t: o_misc_outs expected %h got %h",
                     $time, m_misc, o_misc_outs);
        end

        // loopback echo and unknown classes
        for (i = 0; i < 8; i++) begin
            r = $random(seed);
            send_cmd(make_cmd({4'h2, r[3:0]}, r[15:8], $random(seed)));
        end
        send_cmd(make_cmd(8'h70, SR_CORE_READBACK, 32'd1));
        send_cmd(make_cmd(8'hE5, SR_CORE_MISC, 32'h1357_9BDF));
        drain_responses();

        // mixed traffic under sparse response credits
        credit_gap = 15;
        for (i = 0; i < N_RAND; i++) begin
            r = $random(seed);
            case (r[3:2])
                2'd0: addr = SR_CORE_MISC;
                2'd1: addr = SR_CORE_READBACK;
                2'd2: addr = SR_CORE_GPSDO_ST;
                default: addr = 8'd77;
            endcase
            if (r[0]) begin
                sid = {4'h2, r[11:8]};
            end else if (r[1]) begin
                sid = {4'h4, r[11:8]};
            end else begin
                sid = {4'hB, r[11:8]};
            end
            send_cmd(make_cmd(sid, addr, $random(seed)));
            if (r[15]) begin
                @(posedge radio_clk);
                #1;
            end
        end
        drain_responses();
        credit_gap = 2;
        assert (o_misc_outs === m_misc) else begin
            mismatch_errs++;
            $display("Mismatch at %0t: o_misc_outs expected %h got %h",
                     $time, m_misc, o_misc_outs);
        end

        // pps sources and time sync
        check_pps_follows(PPS_SEL_GPSDO);
        check_pps_follows(PPS_SEL_EXT);
        send_cmd(make_cmd(SID_LOCAL, SR_CORE_SYNC, {29'b0, 1'b1, PPS_SEL_OFF}));
        drain_responses();
        assert (o_time_sync === m_sync[2]) else begin
            mismatch_errs++;
            $display("Mismatch at %0t: o_time_sync expected %b got %b",
                     $time, m_sync[2], o_time_sync);
        end
        i_pps_int = 1'b1;
        i_pps_ext = 1'b1;
        seen_hi   = 1'b0;
        repeat (10) begin
            @(negedge radio_clk);
            seen_hi = seen_hi | o_pps;
        end
        @(posedge radio_clk);
        #1;
        i_pps_int = 1'b0;
        i_pps_ext = 1'b0;
        assert (!seen_hi) else begin
            other_errs++;
            $display("%0t: o_pps went high with the PPS source switched off", $time);
        end

        send_cmd(make_cmd(SID_LOCAL, SR_CORE_SYNC, {30'b0, PPS_SEL_INT}));
        drain_responses();
        assert (o_time_sync === m_sync[2]) else begin
            mismatch_errs++;
            $display("Mismatch at %0t: o_time_sync expected %b got %b",
                     $time, m_sync[2], o_time_sync);
        end
        seen_hi = 1'b0;
        seen_lo = 1'b0;
        repeat (2 * INT_PPS_PERIOD) begin
            @(negedge radio_clk);
            seen_hi = seen_hi | o_pps;
            seen_lo = seen_lo | !o_pps;
        end
        assert (seen_hi && seen_lo) else begin
            other_errs++;
            $display("%0t: internal PPS did not toggle on o_pps", $time);
        end

        $display("errors: %0d mismatch, %0d other, %0d commands sent",
                 mismatch_errs, other_errs, sent);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
b200_core_pkg.sv
ctrl_demux.sv
core_ctrl_proc.sv
pps_select.sv
resp_mux.sv
b200_core.sv
tb_b200_core.sv
